/* Bender.yml */
package:
  name: mipsPipe

sources:
  - mipsPkg.sv
  - mipsDecoder.sv
  - mipsRegFile.sv
  - mipsAlu.sv
  - mipsHazard.sv
  - mipsDatapath.sv
  - target: simulation
    files:
      - mipsTbClock.sv
      - mipsTb.sv

/* mipsAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsAlu (
    input  logic [3:0]                    aluOp,
    input  logic [mipsPkg::dataWidth-1:0] srcA,
    input  logic [mipsPkg::dataWidth-1:0] srcB,
    input  logic [4:0]                    shamt,
    input  logic [mipsPkg::dataWidth-1:0] rsVal,
    input  logic [mipsPkg::dataWidth-1:0] rtVal,
    input  logic                          branch,
    input  logic                          branchNe,
    output logic [mipsPkg::dataWidth-1:0] result,
    output logic                          taken
);
    import mipsPkg::*;

    logic equal;

    always_comb begin
        case (aluOp)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSll:  result = srcB << shamt;  // rt shifted
            aluLui:  result = {srcB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // branch compare uses the forwarded register values
    assign equal = (rsVal == rtVal);
    assign taken = branch && (branchNe ? !equal : equal);

endmodule

`default_nettype wire

/* mipsDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsDatapath #(
    parameter logic [mipsPkg::dataWidth-1:0] resetPc = 32'hbfc0_0000
) (
    input  logic                          clk,
    input  logic                          rstN,
    output logic [mipsPkg::dataWidth-1:0] pcF,
    output logic                          instEnF,
    input  logic [mipsPkg::dataWidth-1:0] instrF,
    input  logic                          iStall,
    output mipsPkg::dataReq               memReq,
    input  logic [mipsPkg::dataWidth-1:0] memRdata,
    input  logic                          dStall,
    output mipsPkg::debugWb               dbgWb
);
    import mipsPkg::*;

    logic                    freeze, stallF, stallD, flushD, flushE;
    logic [1:0]              fwdA, fwdB;
    logic [dataWidth-1:0]    pcNext;
    // decode
    instrWord                instrD;
    ctrlSig                  ctrlD;
    logic                    jumpD;
    logic [dataWidth-1:0]    pcD, pcPlus4D, rd1D, rd2D, immD, branchTargetD, jumpTargetD;
    logic [regAddrWidth-1:0] destD;
    // execute
    ctrlSig                  ctrlE;
    logic [dataWidth-1:0]    pcE, rd1E, rd2E, immE, branchTargetE;
    logic [dataWidth-1:0]    srcAE, rtValE, srcBE, aluOutE;
    logic [regAddrWidth-1:0] rsE, rtE, destE;
    logic [4:0]              shamtE;
    logic                    takenE;
    // memory
    ctrlSig                  ctrlM;
    logic [dataWidth-1:0]    pcM, aluOutM, rtValM, resultM;
    logic [regAddrWidth-1:0] destM;
    logic                    wenM, storeDone;
    // writeback
    logic                    regWriteW;
    logic [regAddrWidth-1:0] destW;
    logic [dataWidth-1:0]    resultW;

    mipsHazard hazard0 (
        .rsD(instrD.rType.rs), .rtD(instrD.rType.rt),
        .rsE(rsE), .rtE(rtE),
        .destE(destE), .destM(destM), .destW(destW),
        .regWriteE(ctrlE.regWrite), .regWriteM(ctrlM.regWrite), .regWriteW(regWriteW),
        .memReadE(ctrlE.memRead), .takenE(takenE),
        .iStall(iStall), .dStall(dStall),
        .freeze(freeze), .stallF(stallF), .stallD(stallD),
        .flushD(flushD), .flushE(flushE),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    // branch in execute wins over j in decode
    assign pcNext = takenE ? branchTargetE : jumpD ? jumpTargetD : pcF + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instEnF <= 1'b0;
            pcF     <= resetPc;
        end else begin
            instEnF <= 1'b1;  // fetch starts one cycle after reset
            if (instEnF && !stallF) begin
                pcF <= pcNext;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= '0;
        end else if (!stallD) begin
            instrD <= (flushD || !instEnF) ? '0 : instrF;  // all zero is sll r0 = nop
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
        end
    end

    mipsDecoder decoder0 (.instr(instrD), .ctrl(ctrlD), .jump(jumpD));

    mipsRegFile regFile0 (
        .clk(clk), .rstN(rstN),
        .we(wenM), .waddr(destM), .wdata(resultM),
        .raddrA(instrD.rType.rs), .raddrB(instrD.rType.rt),
        .rdataA(rd1D), .rdataB(rd2D)
    );

    assign pcPlus4D = pcD + 32'd4;
    assign immD = ctrlD.signExt ? {{16{instrD.iType.imm16[15]}}, instrD.iType.imm16}
                                : {16'h0000, instrD.iType.imm16};
    assign branchTargetD = pcPlus4D
                         + {{14{instrD.iType.imm16[15]}}, instrD.iType.imm16, 2'b00};
    assign jumpTargetD = {pcPlus4D[31:28], instrD.jType.target26, 2'b00};
    assign destD = ctrlD.destRt ? instrD.rType.rt : instrD.rType.rd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlE <= '0;
        end else if (!freeze) begin
            ctrlE <= flushE ? '0 : ctrlD;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcE           <= pcD;
            rsE           <= instrD.rType.rs;
            rtE           <= instrD.rType.rt;
            destE         <= destD;
            shamtE        <= instrD.rType.shamt;
            rd1E          <= rd1D;
            rd2E          <= rd2D;
            immE          <= immD;
            branchTargetE <= branchTargetD;
        end
    end

    // memory stage forwards the ALU result, a load there is excluded by the stall
    function automatic logic [dataWidth-1:0] pickFwd(input logic [1:0] sel,
                                                     input logic [dataWidth-1:0] rfVal);
        case (sel)
            2'd1:    return aluOutM;
            2'd2:    return resultW;
            default: return rfVal;
        endcase
    endfunction

    always_comb begin
        srcAE  = pickFwd(fwdA, rd1E);
        rtValE = pickFwd(fwdB, rd2E);
    end
    assign srcBE = ctrlE.useImm ? immE : rtValE;

    mipsAlu alu0 (
        .aluOp(ctrlE.aluOp), .srcA(srcAE), .srcB(srcBE), .shamt(shamtE),
        .rsVal(srcAE), .rtVal(rtValE),
        .branch(ctrlE.branch), .branchNe(ctrlE.branchNe),
        .result(aluOutE), .taken(takenE)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlM <= '0;
        end else if (!freeze) begin
            ctrlM <= ctrlE;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcM     <= pcE;
            destM   <= destE;
            aluOutM <= aluOutE;
            rtValM  <= rtValE;
        end
    end

    // a store that completed under iStall is not issued again
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            storeDone <= 1'b0;
        end else if (!freeze) begin
            storeDone <= 1'b0;
        end else if (memReq.en && memReq.we && !dStall) begin
            storeDone <= 1'b1;
        end
    end

    always_comb begin
        memReq.en    = ctrlM.memRead || (ctrlM.memWrite && !storeDone);
        memReq.we    = ctrlM.memWrite && !storeDone;
        memReq.addr  = aluOutM;
        memReq.wdata = rtValM;
    end

    assign resultM = ctrlM.memRead ? memRdata : aluOutM;
    assign wenM    = ctrlM.regWrite && destM != '0 && !freeze;

    always_comb begin
        dbgWb.pc    = pcM;
        dbgWb.wen   = wenM;
        dbgWb.wnum  = destM;
        dbgWb.wdata = resultM;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
        end else if (!freeze) begin
            regWriteW <= ctrlM.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            destW   <= destM;
            resultW <= resultM;
        end
    end

    wordAligned: assert property (@(posedge clk) disable iff (!rstN)
        memReq.en |-> memReq.addr[1:0] == 2'b00)
        else $error("unaligned data access at %h", memReq.addr);

endmodule

`default_nettype wire

/* mipsDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsDecoder (
    input  mipsPkg::instrWord instr,
    output mipsPkg::ctrlSig   ctrl,
    output logic              jump
);
    import mipsPkg::*;

    always_comb begin
        ctrl = '0;  // anything unmatched stays a nop
        jump = 1'b0;
        case (instr.rType.opcode)
            opRtype: begin
                ctrl.regWrite = 1'b1;
                case (instr.rType.funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSll:  ctrl.aluOp = aluSll;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                ctrl.aluOp    = aluAdd;
                ctrl.useImm   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.destRt   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opOri: begin
                ctrl.aluOp    = aluOr;
                ctrl.useImm   = 1'b1;  // zero extended
                ctrl.destRt   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLui: begin
                ctrl.aluOp    = aluLui;
                ctrl.useImm   = 1'b1;
                ctrl.destRt   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLw: begin
                ctrl.aluOp    = aluAdd;
                ctrl.useImm   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.destRt   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            opSw: begin
                ctrl.aluOp    = aluAdd;
                ctrl.useImm   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.branch  = 1'b1;
                ctrl.signExt = 1'b1;
            end
            opBne: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.signExt  = 1'b1;
            end
            opJ: jump = 1'b1;  // redirected in decode
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mipsHazard.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsHazard (
    input  logic [mipsPkg::regAddrWidth-1:0] rsD,
    input  logic [mipsPkg::regAddrWidth-1:0] rtD,
    input  logic [mipsPkg::regAddrWidth-1:0] rsE,
    input  logic [mipsPkg::regAddrWidth-1:0] rtE,
    input  logic [mipsPkg::regAddrWidth-1:0] destE,
    input  logic [mipsPkg::regAddrWidth-1:0] destM,
    input  logic [mipsPkg::regAddrWidth-1:0] destW,
    input  logic                             regWriteE,
    input  logic                             regWriteM,
    input  logic                             regWriteW,
    input  logic                             memReadE,
    input  logic                             takenE,
    input  logic                             iStall,
    input  logic                             dStall,
    output logic                             freeze,
    output logic                             stallF,
    output logic                             stallD,
    output logic                             flushD,
    output logic                             flushE,
    output logic [1:0]                       fwdA,
    output logic [1:0]                       fwdB
);
    import mipsPkg::*;

    logic loadUse;

    // 1 = memory stage, 2 = writeback, 0 = register file
    function automatic logic [1:0] fwdSel(input logic [regAddrWidth-1:0] src);
        if (regWriteM && destM != '0 && destM == src) begin
            return 2'd1;
        end
        if (regWriteW && destW != '0 && destW == src) begin
            return 2'd2;
        end
        return 2'd0;
    endfunction

    assign freeze  = iStall || dStall;
    assign loadUse = memReadE && regWriteE && destE != '0 && (destE == rsD || destE == rtD);

    assign stallF = freeze || loadUse;
    assign stallD = freeze || loadUse;
    assign flushE = loadUse && !freeze;  // bubble behind the load
    assign flushD = takenE && !freeze;   // drops the instruction after the delay slot

    always_comb begin
        fwdA = fwdSel(rsE);
        fwdB = fwdSel(rtE);
    end

endmodule

`default_nettype wire

/* mipsPipe.f */
mipsPkg.sv
mipsDecoder.sv
mipsRegFile.sv
mipsAlu.sv
mipsHazard.sv
mipsDatapath.sv
mipsTbClock.sv
mipsTb.sv

/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    // primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // funct field, only under opRtype
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam logic [3:0] aluAdd = 4'd0;
    localparam logic [3:0] aluSub = 4'd1;
    localparam logic [3:0] aluAnd = 4'd2;
    localparam logic [3:0] aluOr  = 4'd3;
    localparam logic [3:0] aluXor = 4'd4;
    localparam logic [3:0] aluSlt = 4'd5;
    localparam logic [3:0] aluSll = 4'd6;
    localparam logic [3:0] aluLui = 4'd7;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rFields;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0]             imm16;
    } iFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFields;

    // same 32 bits, three views
    typedef union packed {
        rFields rType;
        iFields iType;
        jFields jType;
    } instrWord;

    typedef struct packed {
        logic [3:0] aluOp;
        logic       useImm;
        logic       signExt;
        logic       destRt;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       branch;
        logic       branchNe;
    } ctrlSig;

    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } dataReq;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic                    wen;
        logic [regAddrWidth-1:0] wnum;
        logic [dataWidth-1:0]    wdata;
    } debugWb;

endpackage

`default_nettype wire

/* mipsRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsRegFile (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             we,
    input  logic [mipsPkg::regAddrWidth-1:0] waddr,
    input  logic [mipsPkg::dataWidth-1:0]    wdata,
    input  logic [mipsPkg::regAddrWidth-1:0] raddrA,
    input  logic [mipsPkg::regAddrWidth-1:0] raddrB,
    output logic [mipsPkg::dataWidth-1:0]    rdataA,
    output logic [mipsPkg::dataWidth-1:0]    rdataB
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, forwarding covers the same-cycle case
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

/* mipsTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsTb;
    import mipsPkg::*;

    localparam logic [dataWidth-1:0] resetPc = 32'h0000_1000;
    localparam int progLen    = 80;
    localparam int dmemDepth  = 256;
    localparam int numTests   = 5;
    localparam int stallOneIn = 4;  // stall high one cycle in four
    localparam int cycleLimit = numTests * (8 * progLen + 50);

    logic                 clk, rstN, iStall, dStall, instEnF;
    logic [dataWidth-1:0] pcF, instrF, memRdata;
    dataReq               memReq;
    debugWb               dbgWb;

    logic [dataWidth-1:0] imem [256];
    logic [dataWidth-1:0] dmem [dmemDepth];
    debugWb               expWb [$];
    dataReq               expSt [$];
    integer               seed = 61;
    int                   errors, passCnt, failCnt, cycles;
    bit                   running, stallOn;
    string                testName;

    mipsTbClock clkGen (.clk(clk));

    mipsDatapath #(.resetPc(resetPc)) i_dut (
        .clk(clk), .rstN(rstN), .pcF(pcF), .instEnF(instEnF), .instrF(instrF),
        .iStall(iStall), .memReq(memReq), .memRdata(memRdata), .dStall(dStall),
        .dbgWb(dbgWb)
    );

    assign instrF   = imem[pcF[9:2]];  // resetPc is 4 KiB aligned
    assign memRdata = dmem[memReq.addr[9:2]];

    function automatic int unsigned rnd(input int unsigned n);
        int unsigned v;
        v = $random(seed);
        return v % n;
    endfunction

    function automatic logic [dataWidth-1:0] fillWord(input int unsigned addr);
        return (addr * 32'h0001_0003) ^ (addr << 24) ^ 32'ha5c3_0f00;
    endfunction

    function automatic string testLabel(input int t);
        case (t)
            0: return "alu";
            1: return "dependencies";
            2: return "branches";
            3: return "stores";
            default: return "stalls";
        endcase
    endfunction

    // 0 reg alu, 1 immediate, 2 lw, 3 sw, 4 branch, 5 j
    function automatic int pickKind(input int test);
        int unsigned r;
        r = rnd(16);
        case (test)
            0: return (r < 8) ? 0 : 1;
            1: return (r < 6) ? 0 : (r < 10) ? 1 : (r < 14) ? 2 : 3;
            2: return (r < 5) ? 0 : (r < 10) ? 1 : (r < 14) ? 4 : 5;
            3: return (r < 4) ? 0 : (r < 8) ? 1 : (r < 12) ? 2 : 3;
            default: return (r < 4) ? 0 : (r < 7) ? 1 : (r < 10) ? 2 : (r < 13) ? 3 :
                            (r < 15) ? 4 : 5;
        endcase
    endfunction

    function automatic logic [4:0] pickReg(input int test);
        return (test == 1) ? 5'(1 + rnd(4)) : 5'(rnd(8));  // few regs keep dependencies dense
    endfunction

    function automatic logic [5:0] pickFunct();
        case (rnd(7))
            0: return fnAddu;
            1: return fnSubu;
            2: return fnAnd;
            3: return fnOr;
            4: return fnXor;
            5: return fnSlt;
            default: return fnSll;
        endcase
    endfunction

    task automatic buildProgram(input int test);
        instrWord w;
        int       kind;
        bit       prevCtrl;
        prevCtrl = 1'b0;
        for (int k = 0; k < 256; k++) begin
            imem[k] = '0;
        end
        for (int k = 0; k < progLen - 2; k++) begin
            kind = pickKind(test);
            if (kind >= 4 && (prevCtrl || k + 9 > progLen - 2)) begin
                kind = 1;  // no control in a delay slot or past the end
            end
            w = '0;
            case (kind)
                0: begin
                    w.rType.funct = pickFunct();
                    w.rType.rs    = (w.rType.funct == fnSll) ? 5'd0 : pickReg(test);
                    w.rType.shamt = (w.rType.funct == fnSll) ? 5'(rnd(32)) : 5'd0;
                    w.rType.rt    = pickReg(test);
                    w.rType.rd    = pickReg(test);
                end
                1: begin
                    w.iType.opcode = (rnd(3) == 0) ? opLui : (rnd(2) == 0) ? opOri : opAddiu;
                    w.iType.rs     = (w.iType.opcode == opLui) ? 5'd0 : pickReg(test);
                    w.iType.rt     = pickReg(test);
                    w.iType.imm16  = 16'(rnd(65536));
                end
                2, 3: begin
                    w.iType.opcode = (kind == 2) ? opLw : opSw;
                    w.iType.rt     = pickReg(test);
                    w.iType.imm16  = 16'(((test == 3) ? rnd(16) : rnd(dmemDepth)) * 4);
                end
                4: begin
                    w.iType.opcode = rnd(2) ? opBeq : opBne;
                    w.iType.rs     = pickReg(test);
                    w.iType.rt     = rnd(2) ? w.iType.rs : pickReg(test);
                    w.iType.imm16  = 16'(1 + rnd(8));
                end
                default: begin
                    w.jType.opcode   = opJ;
                    w.jType.target26 = 26'(resetPc[27:2] + k + 2 + rnd(8));
                end
            endcase
            imem[k]  = w;
            prevCtrl = (kind >= 4);
        end
        imem[progLen - 2] = {opJ, 26'(resetPc[27:2] + progLen - 2)};  // spin here
        imem[progLen - 1] = '0;
    endtask

    // reference interpreter with one delay slot per control instruction
    task automatic runModel();
        logic [dataWidth-1:0] regs [32];
        logic [dataWidth-1:0] mem [dmemDepth];
        logic [dataWidth-1:0] a, b, imm, res;
        logic [4:0]           dest;
        instrWord             w;
        debugWb               wbEntry;
        dataReq               stEntry;
        int                   pc, npc, nxt;
        bit                   wr;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < dmemDepth; k++) begin
            mem[k] = fillWord(k);
        end
        expWb.delete();
        expSt.delete();
        pc  = 0;
        npc = 1;
        while (pc != progLen - 2) begin
            w    = imem[pc];
            a    = regs[w.rType.rs];
            b    = regs[w.rType.rt];
            imm  = {{16{w.iType.imm16[15]}}, w.iType.imm16};
            nxt  = npc + 1;
            wr   = 1'b1;
            dest = w.iType.rt;
            res  = '0;
            case (w.rType.opcode)
                opRtype: begin
                    dest = w.rType.rd;
                    case (w.rType.funct)
                        fnAddu:  res = a + b;
                        fnSubu:  res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnXor:   res = a ^ b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSll:   res = b << w.rType.shamt;
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = a + imm;
                opOri:   res = a | {16'h0000, w.iType.imm16};
                opLui:   res = {w.iType.imm16, 16'h0000};
                opLw:    res = mem[imm[9:2]];
                opSw: begin
                    wr = 1'b0;
                    mem[imm[9:2]] = b;
                    stEntry = {1'b1, 1'b1, imm, b};
                    expSt.push_back(stEntry);
                end
                opBeq, opBne: begin
                    wr = 1'b0;
                    if ((a == b) == (w.rType.opcode == opBeq)) begin
                        nxt = npc + int'(w.iType.imm16);
                    end
                end
                opJ: begin
                    wr  = 1'b0;
                    nxt = int'(w.jType.target26 - resetPc[27:2]);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                regs[dest] = res;
                wbEntry    = {resetPc + 32'(4 * pc), 1'b1, dest, res};
                expWb.push_back(wbEntry);
            end
            pc  = npc;
            npc = nxt;
        end
    endtask

    task automatic checkWb(input debugWb got);
        debugWb want;
        if (expWb.size() == 0) begin
            $display("unexpected register write r%0d = %h from pc %h", got.wnum, got.wdata, got.pc);
            errors++;
        end else begin
            want = expWb.pop_front();
            if (got.pc !== want.pc || got.wnum !== want.wnum || got.wdata !== want.wdata) begin
                $display("[ERROR] %0t: write pc %h r%0d = %h, expected pc %h r%0d = %h", $time,
                         got.pc, got.wnum, got.wdata, want.pc, want.wnum, want.wdata);
                errors++;
            end
        end
    endtask

    task automatic checkStore(input dataReq got);
        dataReq want;
        if (expSt.size() == 0) begin
            $display("unexpected store of %h to %h", got.wdata, got.addr);
            errors++;
        end else begin
            want = expSt.pop_front();
            if (got.addr !== want.addr || got.wdata !== want.wdata) begin
                $display("[ERROR] %0t: store %h to %h, expected %h to %h", $time,
                         got.wdata, got.addr, want.wdata, want.addr);
                errors++;
            end
        end
    endtask

    task automatic expectLow(input logic got, input string what);
        if (got !== 1'b0) begin
            $display("[ERROR] %0t: %s is not low during reset", $time, what);
            errors++;
        end
    endtask

    task automatic checkFetch(input logic [dataWidth-1:0] got);
        if (got !== resetPc) begin
            $display("[ERROR] %0t: first fetch at %h, expected %h", $time, got, resetPc);
            errors++;
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (5) begin
            @(negedge clk);
            expectLow(instEnF, "instEnF");
            expectLow(memReq.en, "memReq.en");
            expectLow(dbgWb.wen, "dbgWb.wen");
        end
        rstN    = 1'b1;
        running = 1'b1;
        @(negedge clk);
        if (instEnF !== 1'b1) begin
            $display("[ERROR] %0t: instEnF did not rise in the first cycle after reset", $time);
            errors++;
        end
        checkFetch(pcF);
    endtask

    always @(negedge clk) begin
        iStall = stallOn && (rnd(stallOneIn) == 0);
        dStall = stallOn && (rnd(stallOneIn) == 0);
    end

    always @(posedge clk) begin
        if (running && rstN) begin
            if (dbgWb.wen) begin
                if (iStall || dStall) begin
                    $display("register write r%0d while a stall is high", dbgWb.wnum);
                    errors++;
                end
                checkWb(dbgWb);
            end
            if (memReq.en && memReq.we && !dStall) begin
                checkStore(memReq);
                dmem[memReq.addr[9:2]] <= memReq.wdata;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test %s did not finish within %0d cycles", testName, cycleLimit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rstN    = 1'b0;
        iStall  = 1'b0;
        dStall  = 1'b0;
        running = 1'b0;
        stallOn = 1'b0;
        passCnt = 0;
        failCnt = 0;
        @(negedge clk);  // first full clock edge under reset
        for (int t = 0; t < numTests; t++) begin
            errors   = 0;
            testName = testLabel(t);
            running  = 1'b0;
            stallOn  = 1'b0;
            buildProgram(t);
            for (int k = 0; k < dmemDepth; k++) begin
                dmem[k] = fillWord(k);
            end
            runModel();
            applyReset();
            stallOn = (t == 4);
            while (expWb.size() != 0 || expSt.size() != 0) begin
                @(negedge clk);
            end
            repeat (8) @(negedge clk);  // self loop must stay quiet
            stallOn = 1'b0;
            running = 1'b0;
            if (errors == 0) begin
                passCnt++;
                $display("test %s passed", testName);
            end else begin
                failCnt++;
                $display("test %s failed with %0d errors", testName, errors);
            end
        end
        $display("%0d tests passed, %0d failed", passCnt, failCnt);
        if (failCnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mipsTbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsTbClock #(
    parameter real periodNs = 4.0
) (
    output logic clk
);
    // starts high so the first falling edge comes half a period in
    initial begin
        clk = 1'b1;
        forever #(periodNs / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire
